// ==== design/rv_isa_pkg.sv ====
package rv_isa_pkg;

   typedef logic [31:0] instr_t;
   typedef logic [6:0]  opcode_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [31:0] imm_t;

   // base opcodes of RV32I plus the system space for CSR access
   localparam opcode_t OP_LUI    = 7'b0110111;
   localparam opcode_t OP_AUIPC  = 7'b0010111;
   localparam opcode_t OP_JAL    = 7'b1101111;
   localparam opcode_t OP_JALR   = 7'b1100111;
   localparam opcode_t OP_BRANCH = 7'b1100011;
   localparam opcode_t OP_LOAD   = 7'b0000011;
   localparam opcode_t OP_STORE  = 7'b0100011;
   localparam opcode_t OP_OPIMM  = 7'b0010011;
   localparam opcode_t OP_OP     = 7'b0110011;
   localparam opcode_t OP_SYSTEM = 7'b1110011;

   typedef enum logic [2:0] {
      FMT_R   = 3'd0,  // no immediate, shifts out zeros
      FMT_I   = 3'd1,
      FMT_S   = 3'd2,
      FMT_B   = 3'd3,
      FMT_U   = 3'd4,
      FMT_J   = 3'd5,
      FMT_CSR = 3'd6   // rs1 field taken as unsigned 5 bit value
   } imm_fmt_t;

endpackage

// ==== design/serial_pkg.sv ====
package serial_pkg;

   typedef logic [4:0] bit_cnt_t;

   typedef enum logic {
      LANE_IDLE  = 1'b0,
      LANE_SHIFT = 1'b1
   } lane_state_t;

   typedef logic [3:0] seg_en_t;
   typedef logic [3:0] seg_ctrl_t;

   // bit positions inside seg_en_t
   localparam int SEG_11_7  = 0;
   localparam int SEG_19_12 = 1;
   localparam int SEG_24_20 = 2;
   localparam int SEG_30_25 = 3;

   // bit positions inside seg_ctrl_t
   localparam int CTRL_TAP_11_7   = 0;  // tap from 11:7 instead of 24:20
   localparam int CTRL_SIGN_30_25 = 1;  // 30:25 fed with the sign bit
   localparam int CTRL_IMM7_30_25 = 2;  // 30:25 fed with bit 7
   localparam int CTRL_SIGN_19_12 = 3;  // 19:12/20 fed with the sign bit

   localparam bit_cnt_t LAST_BIT = 5'd31;

endpackage

// ==== design/imm_dispatch.sv ====
`timescale 1ns/1ps

module imm_dispatch #(
   parameter int N_LANES = 4
) (
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_valid,
   input  rv_isa_pkg::instr_t   i_instr,
   input  logic [N_LANES-1:0]   i_lane_busy,
   output logic [N_LANES-1:0]   o_load,
   output rv_isa_pkg::instr_t   o_instr,
   output logic                 o_drop
);

   localparam int PTR_W = $clog2(N_LANES);

   logic [PTR_W-1:0] ptr;
   logic             ptr_busy;
   logic             accept;

   assign ptr_busy = i_lane_busy[ptr];
   assign accept   = i_valid & ~ptr_busy;

   // no search for a free lane, so results leave in arrival order
   assign o_drop  = i_valid & ptr_busy;
   assign o_instr = i_instr;  // all lanes share the bus, o_load picks one

   always_comb begin
      o_load = '0;
      if (accept) begin
         o_load[ptr] = 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         ptr <= '0;
      end else if (accept) begin
         if (ptr == PTR_W'(N_LANES - 1)) begin
            ptr <= '0;  // lane count need not be a power of two
         end else begin
            ptr <= ptr + 1'b1;
         end
      end
   end

endmodule

// ==== design/imm_lane.sv ====
`timescale 1ns/1ps

module imm_lane #(
   parameter int SHARED_ADDR_REGS = 1
) (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_load,
   input  rv_isa_pkg::instr_t    i_instr,
   output logic                  o_busy,
   output logic                  o_bit,
   output logic                  o_bit_en,
   output rv_isa_pkg::imm_fmt_t  o_fmt,
   output rv_isa_pkg::reg_addr_t o_rd_addr,
   output rv_isa_pkg::reg_addr_t o_rs1_addr,
   output rv_isa_pkg::reg_addr_t o_rs2_addr
);

   import rv_isa_pkg::*;
   import serial_pkg::*;

   localparam bit_cnt_t U_LOW_BITS = 5'd12;

   lane_state_t state;
   bit_cnt_t    cnt;
   opcode_t     opcode;
   imm_fmt_t    fmt;
   imm_fmt_t    fmt_dec;
   seg_en_t     seg_en;
   seg_en_t     en_dec;
   seg_ctrl_t   seg_ctrl;
   seg_ctrl_t   ctrl_dec;

   logic       imm31;
   logic [8:0] imm19_12_20;  // {19:12, 20}
   logic       imm7;
   logic [5:0] imm30_25;
   logic [4:0] imm24_20;
   logic [4:0] imm11_7;

   logic shift;
   logic last;
   logic is_csr;
   logic signbit;
   logic tap;
   logic zero_bit;

   assign opcode = i_instr[6:0];

   always_comb begin
      case (opcode)
         OP_JALR, OP_LOAD, OP_OPIMM: fmt_dec = FMT_I;
         OP_STORE:                   fmt_dec = FMT_S;
         OP_BRANCH:                  fmt_dec = FMT_B;
         OP_LUI, OP_AUIPC:           fmt_dec = FMT_U;
         OP_JAL:                     fmt_dec = FMT_J;
         OP_SYSTEM:                  fmt_dec = i_instr[14] ? FMT_CSR : FMT_R;
         OP_OP:                      fmt_dec = FMT_R;
         default:                    fmt_dec = FMT_R;
      endcase
   end

   // segment enables and feed selection for each format
   always_comb begin
      case (fmt_dec)
         FMT_I:   begin en_dec = 4'b1100; ctrl_dec = 4'b0010; end
         FMT_S:   begin en_dec = 4'b1001; ctrl_dec = 4'b0011; end
         FMT_B:   begin en_dec = 4'b1001; ctrl_dec = 4'b0101; end
         FMT_U:   begin en_dec = 4'b1110; ctrl_dec = 4'b0000; end  // 20 bit ring
         FMT_J:   begin en_dec = 4'b1110; ctrl_dec = 4'b1000; end
         FMT_CSR: begin en_dec = 4'b0010; ctrl_dec = 4'b1000; end
         default: begin en_dec = 4'b0000; ctrl_dec = 4'b0000; end
      endcase
   end

   assign shift    = (state == LANE_SHIFT);
   assign last     = (cnt == LAST_BIT);
   assign o_busy   = shift;
   assign o_bit_en = shift;
   assign o_fmt    = fmt;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state <= LANE_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            LANE_IDLE: begin
               cnt <= '0;
               if (i_load) begin
                  state <= LANE_SHIFT;
               end
            end
            LANE_SHIFT: begin
               cnt <= cnt + 1'b1;
               if (last) begin
                  state <= LANE_IDLE;  // 32 bits sent, cnt wraps to zero
               end
            end
            default: state <= LANE_IDLE;
         endcase
      end
   end

   assign is_csr  = (fmt == FMT_CSR);
   assign signbit = imm31 & ~is_csr;

   always_ff @(posedge i_clk) begin
      if (i_load) begin
         fmt         <= fmt_dec;
         seg_en      <= en_dec;
         seg_ctrl    <= ctrl_dec;
         imm31       <= i_instr[31];
         imm19_12_20 <= {i_instr[19:12], i_instr[20]};
         imm7        <= i_instr[7];
         imm30_25    <= i_instr[30:25];
         imm24_20    <= i_instr[24:20];
         imm11_7     <= i_instr[11:7];
      end else if (shift) begin
         imm7 <= signbit;
         if (seg_en[SEG_19_12]) begin
            imm19_12_20 <= {seg_ctrl[CTRL_SIGN_19_12] ? signbit : imm24_20[0],
                            imm19_12_20[8:1]};
         end
         if (seg_en[SEG_30_25]) begin
            imm30_25 <= {seg_ctrl[CTRL_IMM7_30_25] ? imm7 :
                         seg_ctrl[CTRL_SIGN_30_25] ? signbit : imm19_12_20[0],
                         imm30_25[5:1]};
         end
         if (seg_en[SEG_24_20]) begin
            imm24_20 <= {imm30_25[0], imm24_20[4:1]};
         end
         if (seg_en[SEG_11_7]) begin
            imm11_7 <= {imm30_25[0], imm11_7[4:1]};
         end
      end
   end

   assign tap = last                     ? signbit :
                is_csr                   ? imm19_12_20[4] :
                seg_ctrl[CTRL_TAP_11_7]  ? imm11_7[0] : imm24_20[0];

   // low bits that the encoding leaves implicit
   always_comb begin
      case (fmt)
         FMT_R:        zero_bit = 1'b1;
         FMT_B, FMT_J: zero_bit = (cnt == '0);
         FMT_U:        zero_bit = (cnt < U_LOW_BITS);
         default:      zero_bit = 1'b0;
      endcase
   end

   assign o_bit = shift & ~zero_bit & tap;

   generate
      if (SHARED_ADDR_REGS != 0) begin : g_shared
         // rs1 slot, then rd or rs2, whichever segment rotates
         logic [9:0] addr_shadow;

         always_ff @(posedge i_clk) begin
            if (i_load) begin
               addr_shadow <= {i_instr[19:15],
                               en_dec[SEG_11_7] ? i_instr[11:7] : i_instr[24:20]};
            end
         end

         assign o_rd_addr  = seg_en[SEG_11_7]  ? addr_shadow[4:0] : imm11_7;
         assign o_rs2_addr = seg_en[SEG_24_20] ? addr_shadow[4:0] : imm24_20;
         assign o_rs1_addr = seg_en[SEG_19_12] ? addr_shadow[9:5] : imm19_12_20[8:4];
      end else begin : g_separate
         reg_addr_t rd_addr;
         reg_addr_t rs1_addr;
         reg_addr_t rs2_addr;

         always_ff @(posedge i_clk) begin
            if (i_load) begin
               rd_addr  <= i_instr[11:7];
               rs1_addr <= i_instr[19:15];
               rs2_addr <= i_instr[24:20];
            end
         end

         assign o_rd_addr  = rd_addr;
         assign o_rs1_addr = rs1_addr;
         assign o_rs2_addr = rs2_addr;
      end
   endgenerate

endmodule

// ==== design/imm_collect.sv ====
`timescale 1ns/1ps

module imm_collect #(
   parameter int N_LANES = 4
) (
   input  logic                                  i_clk,
   input  logic                                  i_rst_n,
   input  logic                  [N_LANES-1:0]   i_bit,
   input  logic                  [N_LANES-1:0]   i_bit_en,
   input  rv_isa_pkg::imm_fmt_t  [N_LANES-1:0]   i_fmt,
   input  rv_isa_pkg::reg_addr_t [N_LANES-1:0]   i_rd_addr,
   input  rv_isa_pkg::reg_addr_t [N_LANES-1:0]   i_rs1_addr,
   input  rv_isa_pkg::reg_addr_t [N_LANES-1:0]   i_rs2_addr,
   output logic                                  o_valid,
   output rv_isa_pkg::imm_t                      o_imm,
   output rv_isa_pkg::imm_fmt_t                  o_fmt,
   output rv_isa_pkg::reg_addr_t                 o_rd_addr,
   output rv_isa_pkg::reg_addr_t                 o_rs1_addr,
   output rv_isa_pkg::reg_addr_t                 o_rs2_addr
);

   import rv_isa_pkg::*;
   import serial_pkg::*;

   localparam int IDX_W = $clog2(N_LANES);

   imm_t             sr  [N_LANES];
   bit_cnt_t         cnt [N_LANES];
   logic [N_LANES-1:0] done;
   logic [IDX_W-1:0] fin_lane;

   logic             pend_valid;
   logic [IDX_W-1:0] pend_lane;
   imm_fmt_t         pend_fmt;
   reg_addr_t        pend_rd;
   reg_addr_t        pend_rs1;
   reg_addr_t        pend_rs2;

   // lsb arrives first, so the word fills from the top down
   always_ff @(posedge i_clk) begin
      for (int l = 0; l < N_LANES; l++) begin
         if (i_bit_en[l]) begin
            sr[l] <= {i_bit[l], sr[l][31:1]};
         end
      end
   end

   always_ff @(posedge i_clk) begin
      for (int l = 0; l < N_LANES; l++) begin
         if (!i_rst_n) begin
            cnt[l] <= '0;
         end else if (i_bit_en[l]) begin
            cnt[l] <= cnt[l] + 1'b1;
         end
      end
   end

   // fixed latency means at most one lane ends in any cycle
   always_comb begin
      fin_lane = '0;
      for (int l = 0; l < N_LANES; l++) begin
         done[l] = i_bit_en[l] & (cnt[l] == LAST_BIT);
         if (done[l]) begin
            fin_lane = IDX_W'(l);
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         pend_valid <= 1'b0;
         o_valid    <= 1'b0;
      end else begin
         pend_valid <= |done;
         o_valid    <= pend_valid;
      end
   end

   // lane fields are sampled with the last bit, the word one cycle later
   always_ff @(posedge i_clk) begin
      pend_lane <= fin_lane;
      pend_fmt  <= i_fmt[fin_lane];
      pend_rd   <= i_rd_addr[fin_lane];
      pend_rs1  <= i_rs1_addr[fin_lane];
      pend_rs2  <= i_rs2_addr[fin_lane];
      if (pend_valid) begin
         o_imm      <= sr[pend_lane];
         o_fmt      <= pend_fmt;
         o_rd_addr  <= pend_rd;
         o_rs1_addr <= pend_rs1;
         o_rs2_addr <= pend_rs2;
      end
   end

endmodule

// ==== design/imm_serial_top.sv ====
`timescale 1ns/1ps

module imm_serial_top #(
   parameter int N_LANES          = 4,
   parameter int SHARED_ADDR_REGS = 1
) (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_valid,
   input  rv_isa_pkg::instr_t    i_instr,
   output logic                  o_valid,
   output rv_isa_pkg::imm_t      o_imm,
   output rv_isa_pkg::imm_fmt_t  o_fmt,
   output rv_isa_pkg::reg_addr_t o_rd_addr,
   output rv_isa_pkg::reg_addr_t o_rs1_addr,
   output rv_isa_pkg::reg_addr_t o_rs2_addr,
   output logic                  o_drop
);

   import rv_isa_pkg::*;

   logic [N_LANES-1:0]      lane_busy;
   logic [N_LANES-1:0]      lane_load;
   logic [N_LANES-1:0]      lane_bit;
   logic [N_LANES-1:0]      lane_bit_en;
   instr_t                  disp_instr;
   imm_fmt_t  [N_LANES-1:0] lane_fmt;
   reg_addr_t [N_LANES-1:0] lane_rd;
   reg_addr_t [N_LANES-1:0] lane_rs1;
   reg_addr_t [N_LANES-1:0] lane_rs2;

   imm_dispatch #(
      .N_LANES     (N_LANES)
   ) u_dispatch (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_valid     (i_valid),
      .i_instr     (i_instr),
      .i_lane_busy (lane_busy),
      .o_load      (lane_load),
      .o_instr     (disp_instr),
      .o_drop      (o_drop)
   );

   for (genvar g = 0; g < N_LANES; g++) begin : g_lane
      imm_lane #(
         .SHARED_ADDR_REGS (SHARED_ADDR_REGS)
      ) u_lane (
         .i_clk      (i_clk),
         .i_rst_n    (i_rst_n),
         .i_load     (lane_load[g]),
         .i_instr    (disp_instr),
         .o_busy     (lane_busy[g]),
         .o_bit      (lane_bit[g]),
         .o_bit_en   (lane_bit_en[g]),
         .o_fmt      (lane_fmt[g]),
         .o_rd_addr  (lane_rd[g]),
         .o_rs1_addr (lane_rs1[g]),
         .o_rs2_addr (lane_rs2[g])
      );
   end

   imm_collect #(
      .N_LANES    (N_LANES)
   ) u_collect (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_bit      (lane_bit),
      .i_bit_en   (lane_bit_en),
      .i_fmt      (lane_fmt),
      .i_rd_addr  (lane_rd),
      .i_rs1_addr (lane_rs1),
      .i_rs2_addr (lane_rs2),
      .o_valid    (o_valid),
      .o_imm      (o_imm),
      .o_fmt      (o_fmt),
      .o_rd_addr  (o_rd_addr),
      .o_rs1_addr (o_rs1_addr),
      .o_rs2_addr (o_rs2_addr)
   );

endmodule

// ==== testbench/imm_serial_assert.sv ====
`timescale 1ns/1ps

module imm_serial_assert #(
   parameter int N_LANES = 4
) (
   input logic                  i_clk,
   input logic                  i_rst_n,
   input logic                  i_valid,
   input logic                  o_valid,
   input logic                  o_drop,
   input logic [N_LANES-1:0]    lane_load,
   input rv_isa_pkg::imm_t      o_imm,
   input rv_isa_pkg::imm_fmt_t  o_fmt,
   input rv_isa_pkg::reg_addr_t o_rd_addr,
   input rv_isa_pkg::reg_addr_t o_rs1_addr,
   input rv_isa_pkg::reg_addr_t o_rs2_addr
);

   localparam int SAMPLE_DELAY = 34;  // o_valid rises after edge 33 and is seen at edge 34

   // a refused strobe must come from outside and must not reach any lane
   a_drop_needs_valid: assert property (
      @(posedge i_clk) disable iff (!i_rst_n) o_drop |-> (i_valid && lane_load == '0)
   ) else $error("o_drop raised without an incoming strobe or with a lane loaded");

   a_fixed_latency: assert property (
      @(posedge i_clk) disable iff (!i_rst_n)
      o_valid |-> $past(i_valid && !o_drop, SAMPLE_DELAY)
   ) else $error("o_valid without an accepted strobe 33 cycles before");

   a_strobes_known: assert property (
      @(posedge i_clk) disable iff (!i_rst_n) !$isunknown({o_valid, o_drop})
   ) else $error("o_valid or o_drop is unknown");

   a_fields_known: assert property (
      @(posedge i_clk) disable iff (!i_rst_n)
      o_valid |-> !$isunknown({o_imm, o_fmt, o_rd_addr, o_rs1_addr, o_rs2_addr})
   ) else $error("output field unknown while o_valid is high");

endmodule

bind imm_serial_top imm_serial_assert #(.N_LANES(N_LANES)) u_assert (.*);

// ==== testbench/tb_imm_serial.sv ====
`timescale 1ns/1ps

module tb_imm_serial;

   import rv_isa_pkg::*;

   localparam int N_LANES = 4;
   localparam int LATENCY = 33;

   typedef struct packed {
      imm_t        imm;
      imm_fmt_t    fmt;
      reg_addr_t   rd;
      reg_addr_t   rs1;
      reg_addr_t   rs2;
      int unsigned due;
   } expect_t;

   logic      i_clk = 1'b0;
   logic      i_rst_n;
   logic      i_valid;
   instr_t    i_instr;
   logic      o_valid;
   logic      o_drop;
   imm_t      o_imm;
   imm_fmt_t  o_fmt;
   reg_addr_t o_rd_addr, o_rs1_addr, o_rs2_addr;

   expect_t     exp_q[$];
   int unsigned free_at [N_LANES];  // first cycle a lane takes a strobe again
   int unsigned rr_ptr = 0;
   int unsigned cyc    = 0;
   int unsigned n_sent = 0;
   // 7'b0001111 is MISC-MEM, outside the decoded set, so it reads as R
   opcode_t ops [11] = '{OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD,
                         OP_STORE, OP_OPIMM, OP_OP, OP_SYSTEM, 7'b0001111};
   instr_t  corner [4] = '{32'hffffffff, 32'h00000000, 32'h7fffffff, 32'h80000000};

   imm_serial_top uut (.*);

   always #50 i_clk = ~i_clk;

   task automatic stop_on_error();
      $display("STATUS: FAIL");
      $fatal(1, "run stopped at cycle %0d", cyc);
   endtask

   task automatic check_field(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("Fail %s: got %0h expected %0h", name, got, exp);
         stop_on_error();
      end
   endtask

   // expected decode, straight from the RV32I immediate layouts
   function automatic expect_t ref_imm(input instr_t ins);
      expect_t e;
      e     = '0;
      e.rd  = ins[11:7];
      e.rs1 = ins[19:15];
      e.rs2 = ins[24:20];
      case (ins[6:0])
         OP_JALR, OP_LOAD, OP_OPIMM: e.fmt = FMT_I;
         OP_STORE:                   e.fmt = FMT_S;
         OP_BRANCH:                  e.fmt = FMT_B;
         OP_LUI, OP_AUIPC:           e.fmt = FMT_U;
         OP_JAL:                     e.fmt = FMT_J;
         OP_SYSTEM:                  e.fmt = ins[14] ? FMT_CSR : FMT_R;
         default:                    e.fmt = FMT_R;
      endcase
      case (e.fmt)
         FMT_I:   e.imm = {{20{ins[31]}}, ins[31:20]};
         FMT_S:   e.imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         FMT_B:   e.imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
         FMT_U:   e.imm = {ins[31:12], 12'h000};
         FMT_J:   e.imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         FMT_CSR: e.imm = {27'd0, ins[19:15]};  // zero extended, never signed
         default: e.imm = '0;
      endcase
      return e;
   endfunction

   function automatic instr_t make_instr(input opcode_t op, input int unsigned mode);
      instr_t ins;
      ins = (mode < 4) ? corner[mode] : $urandom();  // modes past the corners are random
      return {ins[31:7], op};
   endfunction

   // one clock of stimulus, the model predicts drops from its own lane timers
   task automatic drive(input logic valid, input instr_t ins);
      logic    exp_drop;
      expect_t e;
      @(negedge i_clk);
      i_valid  = valid;
      i_instr  = ins;
      exp_drop = valid && (cyc < free_at[rr_ptr]);
      #1;
      check_field("o_drop", 32'(o_drop), 32'(exp_drop));
      n_sent += valid;
      if (valid && !exp_drop) begin
         e     = ref_imm(ins);
         e.due = cyc + LATENCY + 1;  // sampled on the falling edge after edge 33
         exp_q.push_back(e);
         free_at[rr_ptr] = cyc + LATENCY;
         rr_ptr = (rr_ptr + 1) % N_LANES;
      end
   endtask

   task automatic idle(input int unsigned n);
      repeat (n) drive(1'b0, '0);
   endtask

   always @(posedge i_clk) begin
      cyc <= cyc + 1;
      if (cyc >= 40 * n_sent + 200) begin
         $display("timeout at cycle %0d after %0d strobes", cyc, n_sent);
         stop_on_error();
      end
   end

   always @(negedge i_clk) begin : compare
      expect_t e;
      if (i_rst_n && o_valid) begin
         assert (exp_q.size() != 0) else begin
            $display("o_valid went high with no accepted instruction pending");
            stop_on_error();
         end
         e = exp_q.pop_front();
         check_field("o_valid cycle", cyc, e.due);
         check_field("o_imm", o_imm, e.imm);
         check_field("o_fmt", 32'(o_fmt), 32'(e.fmt));
         check_field("o_rd_addr", 32'(o_rd_addr), 32'(e.rd));
         check_field("o_rs1_addr", 32'(o_rs1_addr), 32'(e.rs1));
         check_field("o_rs2_addr", 32'(o_rs2_addr), 32'(e.rs2));
      end
   end

   initial begin
      int unsigned burst;
      void'($urandom(17));
      i_rst_n = 1'b0;
      i_valid = 1'b0;
      i_instr = '0;
      repeat (4) @(negedge i_clk);
      i_rst_n = 1'b1;
      idle(5);
      // every opcode with each corner pattern and one random word, well apart
      foreach (ops[i]) begin
         for (int m = 0; m < 5; m++) begin
            drive(1'b1, make_instr(ops[i], m));
            idle(LATENCY + 1);
         end
      end
      for (int k = 0; k < 2 * N_LANES + 3; k++) begin
         drive(1'b1, make_instr(ops[k % $size(ops)], 4));  // lanes full after N_LANES
      end
      idle(LATENCY + 1);
      // lane 0 is hit one cycle before and exactly when it is free again
      repeat (N_LANES) drive(1'b1, make_instr(OP_BRANCH, 4));
      idle(LATENCY - N_LANES - 1);
      repeat (2) drive(1'b1, make_instr(OP_JAL, 4));
      idle(LATENCY + 1);
      repeat (60) begin
         burst = $urandom_range(8, 1);
         repeat (burst) begin
            drive(1'b1, make_instr(ops[$urandom_range($size(ops) - 1, 0)],
                                   $urandom_range(6, 0)));
         end
         idle($urandom_range(40, 0));
      end
      idle(LATENCY + 2);
      if (exp_q.size() == 0) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         $display("%0d accepted instructions never reached o_valid", exp_q.size());
         stop_on_error();
      end
   end

endmodule

// ==== src.f ====
design/rv_isa_pkg.sv
design/serial_pkg.sv
design/imm_dispatch.sv
design/imm_lane.sv
design/imm_collect.sv
design/imm_serial_top.sv
testbench/imm_serial_assert.sv
testbench/tb_imm_serial.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_imm_serial
FILELIST = src.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
